//--- verilog/fetch_pkg.sv
package fetch_pkg;

    localparam int addr_width = 32;
    localparam int inst_width = 32;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [inst_width-1:0] inst_t;

    // major opcodes seen by predecode
    typedef enum logic [6:0] {
        op_other  = 7'b0000000,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011
    } opcode_e;

    // fs_wait means one read is outstanding
    typedef enum logic [0:0] {
        fs_idle = 1'b0,
        fs_wait = 1'b1
    } fetch_state_e;

    // memory fault class, passed through to decode untouched
    typedef enum logic [1:0] {
        fault_none     = 2'b00,
        fault_access   = 2'b01,
        fault_misalign = 2'b10
    } fault_e;

    // addi x0, x0, 0
    localparam inst_t inst_nop = 32'h00000013;

endpackage

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl #(
    parameter fetch_pkg::addr_t reset_addr = '0
) (
    input  logic             clk,
    input  logic             rst_n,

    output logic             mem_req_valid,
    output fetch_pkg::addr_t mem_req_addr,
    input  logic             mem_req_ready,

    input  logic             mem_resp_valid,
    input  fetch_pkg::inst_t mem_resp_data,
    input  logic             mem_resp_error,

    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_addr,

    output logic             q_push,
    output fetch_pkg::addr_t q_addr,
    output logic             q_kill,
    input  logic             q_space,

    output fetch_pkg::inst_t fetch_word,
    output fetch_pkg::addr_t fetch_pc,
    input  logic             is_jal,
    input  logic             is_branch,
    input  fetch_pkg::addr_t jal_target,
    input  fetch_pkg::addr_t br_target,

    output fetch_pkg::addr_t lookup_pc,
    input  logic             pred_taken
);

    import fetch_pkg::*;

    fetch_state_e state;
    addr_t        req_pc;
    addr_t        next_pc;
    logic         drop;

    logic         resp_in;
    logic         can_issue;
    logic         req_fire;
    addr_t        seq_pc;
    addr_t        word_next;

    assign resp_in   = (state == fs_wait) && mem_resp_valid;
    // one outstanding read; a returning response frees the slot this cycle
    assign can_issue = (state == fs_idle) || resp_in;

    // kill frees the whole queue, so a redirect need not wait for space
    assign mem_req_valid = can_issue && (redirect_valid || q_space);
    assign req_fire      = mem_req_valid && mem_req_ready;

    assign q_push = resp_in && !drop && !redirect_valid;
    assign q_addr = req_pc;
    assign q_kill = redirect_valid;

    // error words become nops so predecode never sees a jump
    assign fetch_word = mem_resp_error ? inst_nop : mem_resp_data;
    assign fetch_pc   = req_pc;
    assign lookup_pc  = is_branch ? req_pc : '0;

    assign seq_pc = req_pc + 32'd4;

    always_comb begin
        if (is_jal) begin
            word_next = jal_target;
        end else if (is_branch && pred_taken) begin
            word_next = br_target;
        end else begin
            word_next = seq_pc;
        end
    end

    always_comb begin
        if (redirect_valid) begin
            mem_req_addr = redirect_addr;
        end else if (q_push) begin
            mem_req_addr = word_next;
        end else begin
            mem_req_addr = next_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= fs_idle;
            req_pc  <= reset_addr;
            next_pc <= reset_addr;
            drop    <= 1'b0;
        end else begin
            if (req_fire) begin
                state  <= fs_wait;
                req_pc <= mem_req_addr;
            end else if (resp_in) begin
                state <= fs_idle;
            end

            // keeps the chosen address until a request takes it
            next_pc <= mem_req_addr;

            if (resp_in) begin
                drop <= 1'b0;
            end else if (redirect_valid && state == fs_wait) begin
                // stale read still in flight
                drop <= 1'b1;
            end
        end
    end

    a_single_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_fire |=> (mem_resp_valid || !req_fire)
    );

    a_no_push_in_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        (redirect_valid && state == fs_wait && !mem_resp_valid) |=> !q_push
    );

endmodule

//--- verilog/inst_predecode.sv
`timescale 1ns/1ps

module inst_predecode (
    input  fetch_pkg::inst_t word,
    input  fetch_pkg::addr_t pc,
    input  logic             word_valid,
    output logic             is_jal,
    output logic             is_branch,
    output fetch_pkg::addr_t jal_target,
    output fetch_pkg::addr_t br_target
);

    import fetch_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [20:0] imm_j;
    logic [12:0] imm_b;
    addr_t       imm_j_sext;
    addr_t       imm_b_sext;
    logic        br_funct_ok;

    always_comb begin
        case (word[6:0])
            op_jal:    opcode = op_jal;
            op_jalr:   opcode = op_jalr;
            op_branch: opcode = op_branch;
            default:   opcode = op_other;
        endcase
    end

    assign funct3 = word[14:12];

    // funct3 010 and 011 are unused in the branch space
    assign br_funct_ok = (funct3 != 3'b010) && (funct3 != 3'b011);

    // J-type immediate
    assign imm_j = {word[31], word[19:12], word[20], word[30:21], 1'b0};

    // B-type immediate
    assign imm_b = {word[31], word[7], word[30:25], word[11:8], 1'b0};

    assign imm_j_sext = {{11{imm_j[20]}}, imm_j};
    assign imm_b_sext = {{19{imm_b[12]}}, imm_b};

    assign jal_target = pc + imm_j_sext;
    assign br_target  = pc + imm_b_sext;

    // jalr target needs a register, so it just falls through
    assign is_jal    = word_valid && (opcode == op_jal);
    assign is_branch = word_valid && (opcode == op_branch) && br_funct_ok;

endmodule

//--- verilog/bimodal_predictor.sv
`timescale 1ns/1ps

module bimodal_predictor #(
    parameter int bht_index_bits = 6
) (
    input  logic             clk,
    input  logic             rst_n,
    input  fetch_pkg::addr_t lookup_pc,
    input  logic             br_valid,
    input  fetch_pkg::addr_t br_pc,
    input  logic             br_taken,
    output logic             pred_taken
);

    localparam int table_size = 2 ** bht_index_bits;

    logic [1:0]                ctr [table_size];
    logic [bht_index_bits-1:0] rd_idx;
    logic [bht_index_bits-1:0] wr_idx;
    logic [1:0]                cur_ctr;
    logic [1:0]                new_ctr;

    // word aligned, so bits 1:0 carry no information
    assign rd_idx = lookup_pc[bht_index_bits+1:2];
    assign wr_idx = br_pc[bht_index_bits+1:2];

    assign pred_taken = ctr[rd_idx][1];

    assign cur_ctr = ctr[wr_idx];

    // saturating update
    always_comb begin
        new_ctr = cur_ctr;
        if (br_taken) begin
            if (cur_ctr != 2'b11) begin
                new_ctr = cur_ctr + 2'b01;
            end
        end else begin
            if (cur_ctr != 2'b00) begin
                new_ctr = cur_ctr - 2'b01;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // weakly not-taken
            for (int i = 0; i < table_size; i++) begin
                ctr[i] <= 2'b01;
            end
        end else if (br_valid) begin
            ctr[wr_idx] <= new_ctr;
        end
    end

endmodule

//--- verilog/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int queue_depth = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               kill,

    input  logic               push,
    input  fetch_pkg::addr_t   push_addr,
    input  fetch_pkg::inst_t   push_inst,
    input  logic               push_error,
    input  fetch_pkg::fault_e  push_fault,
    input  logic               reserve,
    output logic               space,

    output logic               pop_valid,
    input  logic               pop_ready,
    output fetch_pkg::addr_t   pop_addr,
    output fetch_pkg::inst_t   pop_inst,
    output logic               pop_error,
    output fetch_pkg::fault_e  pop_fault
);

    import fetch_pkg::*;

    localparam int ptr_bits = $clog2(queue_depth);
    localparam int cnt_bits = ptr_bits + 1;

    addr_t  addr_mem  [queue_depth];
    inst_t  inst_mem  [queue_depth];
    logic   error_mem [queue_depth];
    fault_e fault_mem [queue_depth];

    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;
    logic                rsv;
    logic                pop_fire;

    assign pop_valid = (count != '0);
    assign pop_fire  = pop_valid && pop_ready;

    // a push turns the reserved slot into an entry, so the sum is unchanged
    assign space = (int'(count) + int'(rsv)) < queue_depth;

    assign pop_addr  = addr_mem[rd_ptr];
    assign pop_inst  = inst_mem[rd_ptr];
    assign pop_error = error_mem[rd_ptr];
    assign pop_fault = fault_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push && !kill) begin
            addr_mem[wr_ptr]  <= push_addr;
            inst_mem[wr_ptr]  <= push_error ? inst_nop : push_inst;
            error_mem[wr_ptr] <= push_error;
            fault_mem[wr_ptr] <= push_fault;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rsv    <= 1'b0;
        end else if (kill) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            // redirect request may be issued in the kill cycle
            rsv    <= reserve;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + cnt_bits'(push) - cnt_bits'(pop_fire);
            if (reserve) begin
                rsv <= 1'b1;
            end else if (push) begin
                rsv <= 1'b0;
            end
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> int'(count) < queue_depth
    );

endmodule

//--- verilog/inst_fetch_top.sv
`timescale 1ns/1ps

module inst_fetch_top #(
    parameter fetch_pkg::addr_t reset_addr     = '0,
    parameter int               queue_depth    = 4,
    parameter int               bht_index_bits = 6
) (
    input  logic              clk,
    input  logic              rst_n,

    output logic              mem_req_valid,
    output fetch_pkg::addr_t  mem_req_addr,
    input  logic              mem_req_ready,

    input  logic              mem_resp_valid,
    input  fetch_pkg::inst_t  mem_resp_data,
    input  logic              mem_resp_error,
    input  fetch_pkg::fault_e mem_resp_fault,

    input  logic              redirect_valid,
    input  fetch_pkg::addr_t  redirect_addr,

    input  logic              br_valid,
    input  fetch_pkg::addr_t  br_pc,
    input  logic              br_taken,

    output logic              dec_valid,
    output fetch_pkg::addr_t  dec_addr,
    output fetch_pkg::inst_t  dec_inst,
    output logic              dec_error,
    output fetch_pkg::fault_e dec_fault,
    input  logic              dec_ready
);

    import fetch_pkg::*;

    logic  q_push;
    addr_t q_addr;
    logic  q_kill;
    logic  q_space;
    logic  q_reserve;
    inst_t fetch_word;
    addr_t fetch_pc;
    logic  is_jal;
    logic  is_branch;
    addr_t jal_target;
    addr_t br_target;
    addr_t lookup_pc;
    logic  pred_taken;

    // slot is reserved when the memory takes the request
    assign q_reserve = mem_req_valid && mem_req_ready;

    fetch_ctrl #(
        .reset_addr(reset_addr)
    ) u_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr(mem_req_addr),
        .mem_req_ready(mem_req_ready),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_data(mem_resp_data),
        .mem_resp_error(mem_resp_error),
        .redirect_valid(redirect_valid),
        .redirect_addr(redirect_addr),
        .q_push(q_push),
        .q_addr(q_addr),
        .q_kill(q_kill),
        .q_space(q_space),
        .fetch_word(fetch_word),
        .fetch_pc(fetch_pc),
        .is_jal(is_jal),
        .is_branch(is_branch),
        .jal_target(jal_target),
        .br_target(br_target),
        .lookup_pc(lookup_pc),
        .pred_taken(pred_taken)
    );

    inst_predecode u_predecode (
        .word(fetch_word),
        .pc(fetch_pc),
        .word_valid(q_push),
        .is_jal(is_jal),
        .is_branch(is_branch),
        .jal_target(jal_target),
        .br_target(br_target)
    );

    bimodal_predictor #(
        .bht_index_bits(bht_index_bits)
    ) u_bht (
        .clk(clk),
        .rst_n(rst_n),
        .lookup_pc(lookup_pc),
        .br_valid(br_valid),
        .br_pc(br_pc),
        .br_taken(br_taken),
        .pred_taken(pred_taken)
    );

    fetch_queue #(
        .queue_depth(queue_depth)
    ) u_queue (
        .clk(clk),
        .rst_n(rst_n),
        .kill(q_kill),
        .push(q_push),
        .push_addr(q_addr),
        .push_inst(mem_resp_data),
        .push_error(mem_resp_error),
        .push_fault(mem_resp_fault),
        .reserve(q_reserve),
        .space(q_space),
        .pop_valid(dec_valid),
        .pop_ready(dec_ready),
        .pop_addr(dec_addr),
        .pop_inst(dec_inst),
        .pop_error(dec_error),
        .pop_fault(dec_fault)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real period_ns    = 20.0,
    parameter int  reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // release on a falling edge, like every other bench input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- bench/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker #(
    parameter fetch_pkg::addr_t reset_addr     = '0,
    parameter fetch_pkg::addr_t err_addr       = '0,
    parameter int               bht_index_bits = 6
) (
    input  logic              clk,
    input  logic              rst_n,
    input  fetch_pkg::inst_t  image [256],
    input  logic              resp_valid,
    input  fetch_pkg::addr_t  resp_addr,
    input  logic              redirect_valid,
    input  fetch_pkg::addr_t  redirect_addr,
    input  logic              br_valid,
    input  fetch_pkg::addr_t  br_pc,
    input  logic              br_taken,
    input  logic              dec_valid,
    input  logic              dec_ready,
    input  fetch_pkg::addr_t  dec_addr,
    input  fetch_pkg::inst_t  dec_inst,
    input  logic              dec_error,
    input  fetch_pkg::fault_e dec_fault,
    output int                errors,
    output int                entries,
    output int                error_entries
);

    import fetch_pkg::*;

    localparam inst_t nop_word = 32'h00000013;

    logic [1:0] model_ctr [2**bht_index_bits];
    // direction the counters gave when each word came back from memory
    logic       taken_at_fetch [256];
    addr_t      exp_addr;

    function automatic logic is_cond_branch(input inst_t w);
        return (w[6:0] == 7'b1100011) && (w[14:13] != 2'b01);
    endfunction

    function automatic addr_t step_after(input addr_t pc, input inst_t w, input logic taken);
        addr_t j_off;
        addr_t b_off;
        j_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        b_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        if (w[6:0] == 7'b1101111) return pc + j_off;
        if (is_cond_branch(w) && taken) return pc + b_off;
        return pc + 32'd4;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
        errors++;
    endtask

    task automatic train(input addr_t pc, input logic taken);
        logic [1:0] c;
        c = model_ctr[pc[bht_index_bits+1:2]];
        if (taken && c != 2'b11) c = c + 2'b01;
        else if (!taken && c != 2'b00) c = c - 2'b01;
        model_ctr[pc[bht_index_bits+1:2]] = c;
    endtask

    task automatic check_entry();
        logic   is_err;
        inst_t  want_inst;
        fault_e want_fault;
        is_err     = (exp_addr == err_addr);
        want_inst  = is_err ? nop_word : image[exp_addr[9:2]];
        want_fault = is_err ? fault_access : fault_none;
        entries++;
        if (is_err) error_entries++;
        if (dec_addr !== exp_addr) report_mismatch("dec_addr", dec_addr, exp_addr);
        if (dec_inst !== want_inst) report_mismatch("dec_inst", dec_inst, want_inst);
        if (dec_error !== is_err) report_mismatch("dec_error", 32'(dec_error), 32'(is_err));
        if (dec_fault !== want_fault) begin
            report_mismatch("dec_fault", 32'(dec_fault), 32'(want_fault));
        end
        exp_addr = step_after(exp_addr, want_inst, taken_at_fetch[exp_addr[9:2]]);
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            errors        = 0;
            entries       = 0;
            error_entries = 0;
            exp_addr      = reset_addr;
            for (int i = 0; i < 2**bht_index_bits; i++) model_ctr[i] = 2'b01;
            for (int i = 0; i < 256; i++) taken_at_fetch[i] = 1'b0;
        end else begin
            // lookup sees the counter before this edge's training
            if (resp_valid) begin
                taken_at_fetch[resp_addr[9:2]] = model_ctr[resp_addr[bht_index_bits+1:2]][1];
            end
            if (dec_valid && dec_ready) check_entry();
            if (redirect_valid) exp_addr = redirect_addr;
            if (br_valid) train(br_pc, br_taken);
        end
    end

endmodule

//--- bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    localparam addr_t reset_addr   = 32'h0000_0000;
    localparam addr_t err_addr     = 32'h0000_0060;
    localparam int    n_rows       = 11;
    localparam int    limit_cycles = n_rows * 40 + 2000;

    typedef struct packed {
        int unsigned wait_cycles;
        logic        redir_v;
        addr_t       redir_a;
        logic        br_v;
        addr_t       br_p;
        logic        br_t;
        logic [7:0]  ready_pat;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        mem_req_valid;
    addr_t       mem_req_addr;
    logic        mem_req_ready  = 1'b0;
    logic        mem_resp_valid = 1'b0;
    inst_t       mem_resp_data  = '0;
    logic        mem_resp_error = 1'b0;
    fault_e      mem_resp_fault = fault_none;
    logic        redirect_valid;
    addr_t       redirect_addr;
    logic        br_valid;
    addr_t       br_pc;
    logic        br_taken;
    logic        dec_valid;
    addr_t       dec_addr;
    inst_t       dec_inst;
    logic        dec_error;
    fault_e      dec_fault;
    logic        dec_ready      = 1'b0;

    inst_t       image [256];
    row_t        rows [n_rows];
    addr_t       pend_addr [$];
    int unsigned pend_due [$];
    addr_t       resp_addr      = '0;
    logic [7:0]  rdy_pat        = 8'hff;
    int unsigned cyc            = 0;
    int          errors;
    int          entries;
    int          error_entries;
    int          bench_errors;

    tb_clock clk_gen (.clk(clk), .rst_n(rst_n));

    inst_fetch_top #(
        .reset_addr(reset_addr),
        .queue_depth(4),
        .bht_index_bits(6)
    ) dut0 (
        .clk(clk), .rst_n(rst_n),
        .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
        .mem_req_ready(mem_req_ready),
        .mem_resp_valid(mem_resp_valid), .mem_resp_data(mem_resp_data),
        .mem_resp_error(mem_resp_error), .mem_resp_fault(mem_resp_fault),
        .redirect_valid(redirect_valid), .redirect_addr(redirect_addr),
        .br_valid(br_valid), .br_pc(br_pc), .br_taken(br_taken),
        .dec_valid(dec_valid), .dec_addr(dec_addr), .dec_inst(dec_inst),
        .dec_error(dec_error), .dec_fault(dec_fault), .dec_ready(dec_ready)
    );

    fetch_checker #(
        .reset_addr(reset_addr),
        .err_addr(err_addr),
        .bht_index_bits(6)
    ) chk0 (
        .clk(clk), .rst_n(rst_n), .image(image),
        .resp_valid(mem_resp_valid), .resp_addr(resp_addr),
        .redirect_valid(redirect_valid), .redirect_addr(redirect_addr),
        .br_valid(br_valid), .br_pc(br_pc), .br_taken(br_taken),
        .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_addr(dec_addr),
        .dec_inst(dec_inst), .dec_error(dec_error), .dec_fault(dec_fault),
        .errors(errors), .entries(entries), .error_entries(error_entries)
    );

    function automatic inst_t enc_jal(input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic inst_t enc_beq(input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], 5'd0, 5'd0, 3'b000, o[4:1], o[11], 7'b1100011};
    endfunction

    // addi x1, x1, word index
    function automatic inst_t fill_word(input logic [7:0] idx);
        return {4'h0, idx, 5'd1, 3'b000, 5'd1, 7'b0010011};
    endfunction

    task automatic apply_row(input row_t row);
        @(negedge clk);
        rdy_pat        <= row.ready_pat;
        redirect_valid = row.redir_v;
        redirect_addr  = row.redir_a;
        br_valid       = row.br_v;
        br_pc          = row.br_p;
        br_taken       = row.br_t;
        @(negedge clk);
        redirect_valid = 1'b0;
        br_valid       = 1'b0;
    endtask

    // memory model, one response per accepted request, in order
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_resp_valid) begin
                pend_addr.delete(0);
                pend_due.delete(0);
            end
            if (mem_req_valid && mem_req_ready) begin
                pend_addr.push_back(mem_req_addr);
                pend_due.push_back(cyc + $urandom_range(3, 1));
            end
        end
        cyc++;
    end

    always @(negedge clk) begin
        mem_req_ready <= ($urandom % 4) != 0;
        dec_ready     <= rdy_pat[cyc[2:0]];
        if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
            mem_resp_valid <= 1'b1;
            resp_addr      <= pend_addr[0];
            mem_resp_data  <= image[pend_addr[0][9:2]];
            mem_resp_error <= (pend_addr[0] == err_addr);
            mem_resp_fault <= (pend_addr[0] == err_addr) ? fault_access : fault_none;
        end else begin
            mem_resp_valid <= 1'b0;
        end
    end

    initial begin
        int target;
        void'($urandom(7));
        bench_errors   = 0;
        redirect_valid = 1'b0;
        redirect_addr  = '0;
        br_valid       = 1'b0;
        br_pc          = '0;
        br_taken       = 1'b0;
        for (int i = 0; i < 256; i++) image[i] = fill_word(8'(i));
        image[8'h08] = enc_jal(32);
        image[8'h11] = enc_beq(8);
        image[8'h14] = enc_beq(48);
        image[8'h1c] = enc_jal(-112);
        image[8'h24] = enc_jal(-144);
        image[8'h84] = enc_jal(-528);
        // wait, redirect valid/addr, branch valid/pc/taken, dec_ready pattern
        rows[0]  = '{80, 1'b0, 32'h000, 1'b0, 32'h000, 1'b0, 8'hff};
        rows[1]  = '{0,  1'b0, 32'h000, 1'b1, 32'h050, 1'b1, 8'hff};
        rows[2]  = '{3,  1'b0, 32'h000, 1'b1, 32'h050, 1'b1, 8'hff};
        rows[3]  = '{60, 1'b0, 32'h000, 1'b0, 32'h000, 1'b0, 8'h00};
        rows[4]  = '{50, 1'b0, 32'h000, 1'b0, 32'h000, 1'b0, 8'ha5};
        rows[5]  = '{40, 1'b1, 32'h200, 1'b0, 32'h000, 1'b0, 8'hff};
        rows[6]  = '{20, 1'b1, 32'h020, 1'b0, 32'h000, 1'b0, 8'h6d};
        rows[7]  = '{30, 1'b0, 32'h000, 1'b0, 32'h000, 1'b0, 8'h00};
        rows[8]  = '{40, 1'b1, 32'h054, 1'b0, 32'h000, 1'b0, 8'h00};
        rows[9]  = '{10, 1'b0, 32'h000, 1'b1, 32'h050, 1'b0, 8'hff};
        rows[10] = '{2,  1'b0, 32'h000, 1'b1, 32'h050, 1'b0, 8'hff};
        @(posedge rst_n);
        for (int r = 0; r < n_rows; r++) begin
            repeat (rows[r].wait_cycles) @(negedge clk);
            apply_row(rows[r]);
        end
        target = entries + 30;
        while (entries < target) @(negedge clk);
        if (error_entries == 0) begin
            $display("no entry from the error address %h reached decode", err_addr);
            bench_errors++;
        end
        $display("entries checked: %0d, checker errors: %0d, bench errors: %0d",
                 entries, errors, bench_errors);
        if (errors == 0 && bench_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: fetch run did not finish within %0d cycles", limit_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- flist.f
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/inst_predecode.sv
verilog/bimodal_predictor.sv
verilog/fetch_queue.sv
verilog/inst_fetch_top.sv
bench/tb_clock.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fetch testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fetch_tb -f flist.f -o fetch_sim || exit 1
out="$(./obj_dir/fetch_sim 2>&1)"
echo "$out"
grep -q "All checks passed" <<< "$out" && echo "run_sim: passed" || { echo "run_sim: failed"; exit 1; }
